// ==== run_sim.sh ====
#!/bin/sh
# Build and run the knight_physics testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module knight_physics_tb -o knight_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/knight_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
  echo "run passed"
  exit 0
else
  echo "run failed"
  exit 1
fi

// ==== verif/knight_model.svh ====
`ifndef KNIGHT_MODEL_SVH
`define KNIGHT_MODEL_SVH

//////////////////////////////////////////////////
// reference model state, one entry per update
//////////////////////////////////////////////////
logic [31:0] rng_state = 32'ha6e8_5d7b;
int          mdl_om_l, mdl_om_r;   // wheel speeds
int          mdl_head, mdl_yaw;    // signed heading and rate
int          mdl_x, mdl_y;         // board coordinates
logic [2:0]  mdl_ir;               // lft, cntr, rght, active low

function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// two's complement wrap to w bits
function automatic int wrap_signed(int v, int w);
  int m;
  m = 1 << w;
  v = v & (m - 1);
  if (v >= m / 2) v = v - m;
  return v;
endfunction

function automatic int wheel_next(int om, int fwd, int rev);
  int acc;
  int nxt;
  acc = (fwd - rev) - (om >>> 4) - (om >>> 6);
  if (acc > 4095) acc = 4095;       // 13 bit clamp
  if (acc < -4096) acc = -4096;
  if (acc > 32 || acc < -32) begin
    nxt = om + (acc >>> 3);
    if (nxt > 32700) nxt = 32700;
    if (nxt < -32700) nxt = -32700;
  end else begin
    nxt = om - (om >>> 6);          // friction
  end
  return nxt;
endfunction

// 0 none, 1 north, 2 south, 3 west, 4 east
function automatic int heading_dir(int code);
  if (code <= 'h048 || code >= 'hFB8) return 1;
  if (code >= 'h7B8 && code <= 'h848) return 2;
  if (code >= 'h3B8 && code <= 'h448) return 3;
  if (code >= 'hBB8 && code <= 'hC48) return 4;
  return 0;
endfunction

function automatic bit tape_hit(int f);
  return (f > 'h3E0 && f < 'h460) || (f > 'hBA0 && f < 'hC20);
endfunction

task automatic model_step(int fl, int rl, int fr, int rr);
  int  sum, step, dir, nx, ny;
  bit  mov, rail, xh, xl, yh, yl;
  logic [2:0] ir;
  mdl_om_l = wheel_next(mdl_om_l, fl, rl);
  mdl_om_r = wheel_next(mdl_om_r, fr, rr);
  mdl_yaw = wrap_signed((mdl_om_r >>> 1) - (mdl_om_l >>> 1), 16);
  if (!mdl_ir[2]) mdl_yaw = wrap_signed(mdl_yaw - 3000, 16);  // jolt from last IRs
  if (!mdl_ir[0]) mdl_yaw = wrap_signed(mdl_yaw + 3000, 16);
  mdl_head = wrap_signed(mdl_head + (mdl_yaw >>> 7) + (mdl_yaw >>> 8) - (mdl_yaw >>> 12)
                         - (mdl_yaw >>> 13) - (mdl_yaw >>> 14), 20);
  dir  = heading_dir((mdl_head & 'hFFFFF) >> 8);
  sum  = mdl_om_l + mdl_om_r;
  step = (sum & 'h1FFFF) >> 13;
  mov  = (mdl_om_l > 1000) && (mdl_om_r > 1000);
  rail = sum > 22000;
  xh = (mdl_x & 'hFFF) > 'h8F0;
  xl = (mdl_x & 'hFFF) < 'h710;
  yh = (mdl_y & 'hFFF) > 'h8F0;
  yl = (mdl_y & 'hFFF) < 'h710;
  nx = mdl_x;
  ny = mdl_y;
  ir = 3'b111;
  if (mov) begin
    case (dir)
      1: begin ny = (mdl_y + step) & 'h7FFF; ir[0] = !(rail && xh); ir[2] = !(rail && xl); end
      2: begin ny = (mdl_y - step) & 'h7FFF; ir[2] = !(rail && xh); ir[0] = !(rail && xl); end
      3: begin nx = (mdl_x - step) & 'h7FFF; ir[0] = !(rail && yh); ir[2] = !(rail && yl); end
      4: begin nx = (mdl_x + step) & 'h7FFF; ir[2] = !(rail && yh); ir[0] = !(rail && yl); end
      default: ;
    endcase
  end
  ir[1] = !(tape_hit(nx & 'hFFF) || tape_hit(ny & 'hFFF));
  if (mov && dir == 1 && ny > 'h5000) ir = 3'b000;  // off the north edge
  mdl_x  = nx;
  mdl_y  = ny;
  mdl_ir = ir;
endtask

`endif

// ==== verif/knight_physics_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module knight_physics_tb;

  localparam int    N_STRAIGHT = 500;   // long enough to reach the next tape line
  localparam int    N_COAST    = 30;
  localparam int    N_BORDER   = 2200;  // cap, stops early once the edge lights
  localparam int    N_SETTLE   = 600;   // cap on the coast down before the pivot
  localparam int    N_PIVOT    = 40;
  localparam int    N_RANDOM   = 150;
  localparam longint WD_NS = longint'(1 + N_STRAIGHT + N_COAST + N_BORDER + N_SETTLE
                                      + N_PIVOT + N_RANDOM) * 2048 * 4 + 200000;

  typedef struct packed {
    logic [10:0] lf;
    logic [10:0] lr;
    logic [10:0] rf;
    logic [10:0] rr;
  } win_duty_t;

  logic clk, rst_n;
  logic lft_pwm_fwd, lft_pwm_rev, rght_pwm_fwd, rght_pwm_rev;
  logic lft_ir_n, cntr_ir_n, rght_ir_n, update;
  logic signed [15:0] yaw_rate;
  logic [14:0] pos_x, pos_y;

  win_duty_t duty_q[$];   // one entry per measured window
  int mode;               // 0 idle, 1 straight, 2 coast, 3 border, 4 pivot, 5 random
  int errors, checks, upd_cnt, tape_falls;
  bit border_seen;

  `include "knight_model.svh"

  knight_physics #(.PWM_BITS(11)) DUT (
    .clk(clk), .rst_n(rst_n),
    .lft_pwm_fwd(lft_pwm_fwd), .lft_pwm_rev(lft_pwm_rev),
    .rght_pwm_fwd(rght_pwm_fwd), .rght_pwm_rev(rght_pwm_rev),
    .lft_ir_n(lft_ir_n), .cntr_ir_n(cntr_ir_n), .rght_ir_n(rght_ir_n),
    .yaw_rate(yaw_rate), .pos_x(pos_x), .pos_y(pos_y), .update(update)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare_value(string sig, int got, int exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %0d expected %0d", $time, sig, got, exp);
    end
  endtask

  function automatic win_duty_t pick_duties();
    win_duty_t w;
    int d;
    w = '0;
    d = 0;
    case (mode)
      1: begin
        d = 800 + int'(next_rand() % 1248);
        w.lf = 11'(d);
        w.rf = 11'(d);
      end
      3: begin
        w.lf = 11'd2047;
        w.rf = 11'd2047;
      end
      4: begin
        d = 1200 + int'(next_rand() % 848);
        w.lf = 11'(d);
        w.rr = 11'(d);
      end
      5: begin
        w.lf = 11'(next_rand() % 2048);
        w.lr = 11'(next_rand() % 512);
        w.rf = 11'(next_rand() % 2048);
        w.rr = 11'(next_rand() % 512);
      end
      default: ;  // all lines idle
    endcase
    return w;
  endfunction

  // slot counter mirrors the meter window from reset release
  task automatic drive_pwm();
    logic [10:0] slot;
    win_duty_t cur;
    slot = '0;
    cur = '0;
    forever begin
      if (slot == 11'd0) begin
        cur = pick_duties();
        duty_q.push_back(cur);
      end
      lft_pwm_fwd  = slot < cur.lf;
      lft_pwm_rev  = slot < cur.lr;
      rght_pwm_fwd = slot < cur.rf;
      rght_pwm_rev = slot < cur.rr;
      slot = slot + 11'd1;
      @(negedge clk);
    end
  endtask

  // outputs held stable at the falling edge
  always @(negedge clk) begin : check_update
    win_duty_t d;
    logic [2:0] prev_ir;
    if (rst_n && update) begin
      if (duty_q.size() == 0) begin
        errors++;
        $display("update pulse with no PWM window measured");
      end else begin
        d = duty_q.pop_front();
        prev_ir = mdl_ir;
        model_step(d.lf, d.lr, d.rf, d.rr);
        if (prev_ir[1] && !mdl_ir[1]) tape_falls++;
        if (mdl_ir == 3'b000) border_seen = 1'b1;
        compare_value("omega_lft", int'(DUT.omega_lft), mdl_om_l);
        compare_value("omega_rght", int'(DUT.omega_rght), mdl_om_r);
        compare_value("yaw_rate", int'(yaw_rate), mdl_yaw);
        compare_value("pos_x", int'(pos_x), mdl_x);
        compare_value("pos_y", int'(pos_y), mdl_y);
        compare_value("lft_ir_n", int'(lft_ir_n), int'(mdl_ir[2]));
        compare_value("cntr_ir_n", int'(cntr_ir_n), int'(mdl_ir[1]));
        compare_value("rght_ir_n", int'(rght_ir_n), int'(mdl_ir[0]));
      end
      upd_cnt++;
    end
  end

  task automatic run_updates(int n);
    int target;
    target = upd_cnt + n;
    while (upd_cnt < target) @(negedge clk);
  endtask

  task automatic report_test(string name, int start_upd, int start_err);
    $display("%s: %0d updates, %0d errors", name, upd_cnt - start_upd, errors - start_err);
  endtask

  initial begin : watchdog
    #(WD_NS);
    $display("watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    int u0, e0, cyc, px, py;
    {lft_pwm_fwd, lft_pwm_rev, rght_pwm_fwd, rght_pwm_rev} = 4'b0;
    rst_n = 1'b0;
    mode = 0;
    mdl_om_l = 0;
    mdl_om_r = 0;
    mdl_head = 0;
    mdl_yaw = 0;
    mdl_x = 'h2800;
    mdl_y = 'h2800;
    mdl_ir = 3'b111;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      drive_pwm();
    join_none

    ////////////////////////////////////////////////// reset state
    u0 = upd_cnt;
    e0 = errors;
    compare_value("yaw_rate", int'(yaw_rate), 0);
    compare_value("pos_x", int'(pos_x), 'h2800);
    compare_value("pos_y", int'(pos_y), 'h2800);
    compare_value("ir", int'({lft_ir_n, cntr_ir_n, rght_ir_n}), 7);
    cyc = 0;
    while (!update) begin
      @(negedge clk);
      cyc++;
    end
    // one full meter window, then three pipe stages
    compare_value("first update cycle", cyc, (1 << 11) + 3);
    @(posedge clk);  // checker has taken the first update
    report_test("reset", u0, e0);

    ////////////////////////////////////////////////// straight, coast, border
    u0 = upd_cnt;
    e0 = errors;
    tape_falls = 0;
    mode = 1;
    run_updates(N_STRAIGHT);
    if (tape_falls == 0) begin
      errors++;
      $display("center IR never fell during the straight drive");
    end
    report_test("straight", u0, e0);
    u0 = upd_cnt;
    e0 = errors;
    mode = 2;
    run_updates(N_COAST);
    report_test("coast", u0, e0);
    u0 = upd_cnt;
    e0 = errors;
    mode = 3;
    for (int i = 0; i < N_BORDER && !border_seen; i++) run_updates(1);
    if (!border_seen) begin
      errors++;
      $display("north border never reached");
    end
    report_test("border", u0, e0);

    ////////////////////////////////////////////////// pivot and random
    // coast until the robot stops so the pivot starts from rest
    mode = 2;
    cyc = 0;
    while ((mdl_om_l > 1000) && (mdl_om_r > 1000) && (cyc < N_SETTLE)) begin
      run_updates(1);
      cyc++;
    end
    if ((mdl_om_l > 1000) && (mdl_om_r > 1000)) begin
      errors++;
      $display("robot still moving when the pivot started");
    end
    mode = 4;
    u0 = upd_cnt;
    e0 = errors;
    px = int'(pos_x);
    py = int'(pos_y);
    for (int i = 0; i < N_PIVOT; i++) begin
      run_updates(1);
      compare_value("lft_ir_n pivot", int'(lft_ir_n), 1);
      compare_value("rght_ir_n pivot", int'(rght_ir_n), 1);
    end
    compare_value("pos_x hold", int'(pos_x), px);
    compare_value("pos_y hold", int'(pos_y), py);
    if (yaw_rate == 0) begin
      errors++;
      $display("pivot produced no yaw rate");
    end
    report_test("pivot", u0, e0);
    u0 = upd_cnt;
    e0 = errors;
    mode = 5;
    run_updates(N_RANDOM);
    report_test("random", u0, e0);

    $display("total: %0d updates, %0d checks, %0d errors", upd_cnt, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verif
verilog/knight_pkg.sv
verilog/pwm_duty_meter.sv
verilog/wheel_dynamics.sv
verilog/platform_heading.sv
verilog/board_tracker.sv
verilog/knight_physics.sv
verif/knight_physics_tb.sv

// ==== verilog/board_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_tracker (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           pose_vld,  // heading just updated
  input  wire  knight_pkg::motion_t     motion,
  input  wire  knight_pkg::pose_t       pose,
  output logic [knight_pkg::POS_W-1:0]  pos_x,
  output logic [knight_pkg::POS_W-1:0]  pos_y,
  output knight_pkg::ir_t               ir,
  output logic                          update     // outputs refreshed
);

  localparam int OW = knight_pkg::OMEGA_W;
  localparam int HW = knight_pkg::HEAD_W;
  localparam int PW = knight_pkg::POS_W;
  localparam int SW = OW + 1;

  // direction windows on heading[19:8]
  localparam logic [11:0] NORTH_HI = 12'h048;
  localparam logic [11:0] NORTH_LO = 12'hFB8;
  localparam logic [11:0] SOUTH_LO = 12'h7B8;
  localparam logic [11:0] SOUTH_HI = 12'h848;
  localparam logic [11:0] WEST_LO  = 12'h3B8;
  localparam logic [11:0] WEST_HI  = 12'h448;
  localparam logic [11:0] EAST_LO  = 12'hBB8;
  localparam logic [11:0] EAST_HI  = 12'hC48;

  typedef enum logic [2:0] {
    DIR_NONE,
    DIR_NORTH,
    DIR_SOUTH,
    DIR_WEST,
    DIR_EAST
  } dir_e;

  logic [11:0]          dir_code;
  dir_e                 dir;
  logic signed [SW-1:0] omega_sum;  // near zero when pivoting
  logic [PW-1:0]        step;
  logic                 moving;
  logic                 rail_on;
  logic                 x_hi, x_lo, y_hi, y_lo;  // near a guardrail
  logic [PW-1:0]        x_nxt;
  logic [PW-1:0]        y_nxt;
  knight_pkg::ir_t      ir_nxt;

  // tape lines sit around 1/4 and 3/4 of a square
  function automatic logic on_line(input logic [11:0] frac);
    on_line = ((frac > 12'h3E0) && (frac < 12'h460)) ||
              ((frac > 12'hBA0) && (frac < 12'hC20));
  endfunction

  //////////////////////////////////////////////////
  // motion decode
  //////////////////////////////////////////////////
  assign dir_code  = pose.heading[HW-1 -: 12];
  assign omega_sum = motion.omega_lft + motion.omega_rght;
  assign step      = PW'(omega_sum[SW-1 -: 4]);  // bits 16..13
  assign moving    = (motion.omega_lft > knight_pkg::MOVE_MIN) &&
                     (motion.omega_rght > knight_pkg::MOVE_MIN);
  assign rail_on   = omega_sum > knight_pkg::RAIL_SPEED;

  assign x_hi = pos_x[11:0] > knight_pkg::RAIL_HI;
  assign x_lo = pos_x[11:0] < knight_pkg::RAIL_LO;
  assign y_hi = pos_y[11:0] > knight_pkg::RAIL_HI;
  assign y_lo = pos_y[11:0] < knight_pkg::RAIL_LO;

  always_comb begin
    if ((dir_code <= NORTH_HI) || (dir_code >= NORTH_LO)) begin
      dir = DIR_NORTH;  // wraps through zero
    end else if ((dir_code >= SOUTH_LO) && (dir_code <= SOUTH_HI)) begin
      dir = DIR_SOUTH;
    end else if ((dir_code >= WEST_LO) && (dir_code <= WEST_HI)) begin
      dir = DIR_WEST;
    end else if ((dir_code >= EAST_LO) && (dir_code <= EAST_HI)) begin
      dir = DIR_EAST;
    end else begin
      dir = DIR_NONE;  // off axis, no travel
    end
  end

  //////////////////////////////////////////////////
  // position and IRs
  //////////////////////////////////////////////////
  always_comb begin
    x_nxt  = pos_x;
    y_nxt  = pos_y;
    ir_nxt = '{lft_n: 1'b1, cntr_n: 1'b1, rght_n: 1'b1};
    if (moving) begin
      // wall side flips with the direction of travel
      case (dir)
        DIR_NORTH: begin
          y_nxt         = pos_y + step;
          ir_nxt.rght_n = !(rail_on && x_hi);
          ir_nxt.lft_n  = !(rail_on && x_lo);
        end
        DIR_SOUTH: begin
          y_nxt         = pos_y - step;
          ir_nxt.lft_n  = !(rail_on && x_hi);
          ir_nxt.rght_n = !(rail_on && x_lo);
        end
        DIR_WEST: begin
          x_nxt         = pos_x - step;
          ir_nxt.rght_n = !(rail_on && y_hi);
          ir_nxt.lft_n  = !(rail_on && y_lo);
        end
        DIR_EAST: begin
          x_nxt         = pos_x + step;
          ir_nxt.lft_n  = !(rail_on && y_hi);
          ir_nxt.rght_n = !(rail_on && y_lo);
        end
        default: ;  // side IRs stay dark
      endcase
    end
    ir_nxt.cntr_n = !(on_line(x_nxt[11:0]) || on_line(y_nxt[11:0]));
    // ran off the north edge, everything lights
    if (moving && (dir == DIR_NORTH) && (y_nxt > knight_pkg::BORDER_Y)) begin
      ir_nxt = '{lft_n: 1'b0, cntr_n: 1'b0, rght_n: 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos_x  <= knight_pkg::START_POS;
      pos_y  <= knight_pkg::START_POS;
      ir     <= '{lft_n: 1'b1, cntr_n: 1'b1, rght_n: 1'b1};
      update <= 1'b0;
    end else begin
      update <= pose_vld;  // third pipe stage
      if (pose_vld) begin
        pos_x <= x_nxt;
        pos_y <= y_nxt;
        ir    <= ir_nxt;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/knight_physics.sv ====
`timescale 1ns/1ps
`default_nettype none

module knight_physics #(
  parameter int PWM_BITS = 11
) (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   lft_pwm_fwd,
  input  wire                                   lft_pwm_rev,
  input  wire                                   rght_pwm_fwd,
  input  wire                                   rght_pwm_rev,
  output logic                                  lft_ir_n,
  output logic                                  cntr_ir_n,
  output logic                                  rght_ir_n,
  output logic signed [knight_pkg::OMEGA_W-1:0] yaw_rate,
  output logic [knight_pkg::POS_W-1:0]          pos_x,
  output logic [knight_pkg::POS_W-1:0]          pos_y,
  output logic                                  update
);

  knight_pkg::duty_pair_t                lft_duty;
  knight_pkg::duty_pair_t                rght_duty;
  logic                                  update_in;   // model tick
  logic signed [knight_pkg::OMEGA_W-1:0] omega_lft;
  logic signed [knight_pkg::OMEGA_W-1:0] omega_rght;
  logic                                  lft_vld;
  logic                                  rght_vld;
  logic                                  motion_vld;
  knight_pkg::motion_t                   motion;
  knight_pkg::pose_t                     pose;
  logic                                  pose_vld;
  knight_pkg::ir_t                       ir;

  //////////////////////////////////////////////////
  // PWM duty meters
  //////////////////////////////////////////////////
  // all four share one window, so one ready serves as the tick
  pwm_duty_meter #(.PWM_BITS(PWM_BITS)) u_meter_lft_fwd (
    .clk(clk), .rst_n(rst_n), .pwm(lft_pwm_fwd),
    .duty(lft_duty.duty_fwd), .ready(update_in)
  );
  pwm_duty_meter #(.PWM_BITS(PWM_BITS)) u_meter_lft_rev (
    .clk(clk), .rst_n(rst_n), .pwm(lft_pwm_rev),
    .duty(lft_duty.duty_rev), .ready()
  );
  pwm_duty_meter #(.PWM_BITS(PWM_BITS)) u_meter_rght_fwd (
    .clk(clk), .rst_n(rst_n), .pwm(rght_pwm_fwd),
    .duty(rght_duty.duty_fwd), .ready()
  );
  pwm_duty_meter #(.PWM_BITS(PWM_BITS)) u_meter_rght_rev (
    .clk(clk), .rst_n(rst_n), .pwm(rght_pwm_rev),
    .duty(rght_duty.duty_rev), .ready()
  );

  //////////////////////////////////////////////////
  // physics pipeline
  //////////////////////////////////////////////////
  wheel_dynamics #(.PWM_BITS(PWM_BITS)) u_wheel_lft (
    .clk(clk), .rst_n(rst_n), .update_in(update_in),
    .duty(lft_duty), .omega(omega_lft), .omega_vld(lft_vld)
  );
  wheel_dynamics #(.PWM_BITS(PWM_BITS)) u_wheel_rght (
    .clk(clk), .rst_n(rst_n), .update_in(update_in),
    .duty(rght_duty), .omega(omega_rght), .omega_vld(rght_vld)
  );

  assign motion     = '{omega_lft: omega_lft, omega_rght: omega_rght};
  assign motion_vld = lft_vld & rght_vld;  // wheels step together

  platform_heading u_heading (
    .clk(clk), .rst_n(rst_n), .motion_vld(motion_vld), .motion(motion),
    .ir(ir), .pose(pose), .pose_vld(pose_vld)
  );

  board_tracker u_tracker (
    .clk(clk), .rst_n(rst_n), .pose_vld(pose_vld), .motion(motion),
    .pose(pose), .pos_x(pos_x), .pos_y(pos_y), .ir(ir), .update(update)
  );

  assign lft_ir_n  = ir.lft_n;
  assign cntr_ir_n = ir.cntr_n;
  assign rght_ir_n = ir.rght_n;
  assign yaw_rate  = pose.yaw_rate;  // settled a cycle before update

endmodule

`default_nettype wire

// ==== verilog/knight_pkg.sv ====
`default_nettype none

package knight_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int OMEGA_W = 16;   // signed wheel speed
  localparam int ALPHA_W = 13;   // signed wheel acceleration
  localparam int HEAD_W  = 20;   // signed heading, top 12 bits pick direction
  localparam int POS_W   = 15;   // board coordinate, 4096 counts per square
  localparam int DUTY_W  = 11;   // default duty reading width

  //////////////////////////////////////////////////
  // physics constants
  //////////////////////////////////////////////////
  localparam int OMEGA_MAX    = 32700;  // wheel speed clamp
  localparam int FRICTION_LIM = 32;     // below this friction takes over
  localparam int MOVE_MIN     = 1000;   // both wheels above this to travel
  localparam int RAIL_SPEED   = 22000;  // speed sum needed for guardrail IRs
  localparam int JOLT         = 3000;   // yaw kick while a side IR is lit

  // guardrail window on low 12 bits of lateral coordinate
  localparam logic [11:0] RAIL_LO = 12'h710;
  localparam logic [11:0] RAIL_HI = 12'h8F0;

  localparam logic [POS_W-1:0] BORDER_Y  = 15'h5000;  // north edge of board
  localparam logic [POS_W-1:0] START_POS = 15'h2800;  // center of square 2,2

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  // IR sensors, all active low
  typedef struct packed {
    logic lft_n;
    logic cntr_n;
    logic rght_n;
  } ir_t;

  // one wheel's two PWM duty readings
  typedef struct packed {
    logic [DUTY_W-1:0] duty_fwd;
    logic [DUTY_W-1:0] duty_rev;
  } duty_pair_t;

  typedef struct packed {
    logic signed [OMEGA_W-1:0] omega_lft;
    logic signed [OMEGA_W-1:0] omega_rght;
  } motion_t;

  typedef struct packed {
    logic signed [HEAD_W-1:0]  heading;
    logic signed [OMEGA_W-1:0] yaw_rate;
  } pose_t;

endpackage

`default_nettype wire

// ==== verilog/platform_heading.sv ====
`timescale 1ns/1ps
`default_nettype none

module platform_heading (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    motion_vld,  // wheel speeds just updated
  input  wire  knight_pkg::motion_t motion,
  input  wire  knight_pkg::ir_t     ir,       // IRs from previous update
  output knight_pkg::pose_t         pose,
  output logic                      pose_vld
);

  localparam int OW = knight_pkg::OMEGA_W;
  localparam int HW = knight_pkg::HEAD_W;

  logic signed [OW-1:0] yaw_base;     // from wheel speed difference only
  logic signed [OW-1:0] yaw_nxt;
  logic signed [HW-1:0] heading_nxt;

  //////////////////////////////////////////////////
  // platform yaw rate
  //////////////////////////////////////////////////
  assign yaw_base = ($signed(motion.omega_rght) >>> 1) -
                    ($signed(motion.omega_lft) >>> 1);

  always_comb begin
    yaw_nxt = yaw_base;
    // guardrail kick steers away from the wall
    if (!ir.lft_n) begin
      yaw_nxt = yaw_nxt - OW'(knight_pkg::JOLT);
    end
    if (!ir.rght_n) begin
      yaw_nxt = yaw_nxt + OW'(knight_pkg::JOLT);
    end
  end

  //////////////////////////////////////////////////
  // heading integration
  //////////////////////////////////////////////////

  // gain near 1/85, built from shifts
  assign heading_nxt = $signed(pose.heading)
                     + (yaw_nxt >>> 7)
                     + (yaw_nxt >>> 8)
                     - (yaw_nxt >>> 12)
                     - (yaw_nxt >>> 13)
                     - (yaw_nxt >>> 14);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pose     <= '0;
      pose_vld <= 1'b0;
    end else begin
      pose_vld <= motion_vld;
      if (motion_vld) begin
        pose.heading  <= heading_nxt;  // wraps mod 2^20
        pose.yaw_rate <= yaw_nxt;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pwm_duty_meter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_duty_meter #(
  parameter int PWM_BITS = 11
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 pwm,    // raw motor drive line
  output logic [PWM_BITS-1:0] duty,   // high count of last full period
  output logic                ready   // one cycle pulse, duty valid
);

  logic [PWM_BITS-1:0] per_cnt;   // free running period counter
  logic [PWM_BITS-1:0] high_cnt;  // edges seen with pwm high
  logic                per_end;

  assign per_end = &per_cnt;  // last slot of the window

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      per_cnt  <= '0;
      high_cnt <= '0;
      duty     <= '0;
      ready    <= 1'b0;
    end else begin
      per_cnt <= per_cnt + 1'b1;
      ready   <= per_end;  // lands with the new duty
      if (per_end) begin
        duty     <= high_cnt;  // reading holds for a whole period
        high_cnt <= '0;        // restart for next window
      end else if (pwm) begin
        high_cnt <= high_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wheel_dynamics.sv ====
`timescale 1ns/1ps
`default_nettype none

module wheel_dynamics #(
  parameter int PWM_BITS = 11
) (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   update_in,  // new duties available
  input  wire  knight_pkg::duty_pair_t          duty,
  output logic signed [knight_pkg::OMEGA_W-1:0] omega,      // wheel speed
  output logic                                  omega_vld
);

  localparam int OW        = knight_pkg::OMEGA_W;
  localparam int AW        = knight_pkg::ALPHA_W;
  localparam int SW        = OW + 1;                // headroom for sums
  localparam int ALPHA_MAX = 2**(AW-1) - 1;
  localparam int ALPHA_MIN = -(2**(AW-1));

  logic signed [PWM_BITS:0] torque;     // fwd minus rev, linear drive
  logic signed [SW-1:0]     alpha_raw;
  logic signed [AW-1:0]     alpha;      // clamped acceleration
  logic                     accel_on;   // beats static friction
  logic signed [SW-1:0]     omega_raw;
  logic signed [OW-1:0]     omega_nxt;

  //////////////////////////////////////////////////
  // acceleration
  //////////////////////////////////////////////////
  assign torque = $signed({1'b0, duty.duty_fwd[PWM_BITS-1:0]}) -
                  $signed({1'b0, duty.duty_rev[PWM_BITS-1:0]});

  // back emf style drag proportional to speed
  assign alpha_raw = torque - (omega >>> 4) - (omega >>> 6);

  always_comb begin
    if (alpha_raw > ALPHA_MAX) begin
      alpha = AW'(ALPHA_MAX);
    end else if (alpha_raw < ALPHA_MIN) begin
      alpha = AW'(ALPHA_MIN);
    end else begin
      alpha = alpha_raw[AW-1:0];
    end
  end

  assign accel_on = (alpha > knight_pkg::FRICTION_LIM) ||
                    (alpha < -knight_pkg::FRICTION_LIM);

  //////////////////////////////////////////////////
  // speed integration
  //////////////////////////////////////////////////
  assign omega_raw = omega + (alpha >>> 3);

  always_comb begin
    if (accel_on) begin
      if (omega_raw > knight_pkg::OMEGA_MAX) begin
        omega_nxt = OW'(knight_pkg::OMEGA_MAX);
      end else if (omega_raw < -knight_pkg::OMEGA_MAX) begin
        omega_nxt = OW'(-knight_pkg::OMEGA_MAX);
      end else begin
        omega_nxt = omega_raw[OW-1:0];
      end
    end else begin
      omega_nxt = omega - (omega >>> 6);  // coast down
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      omega     <= '0;
      omega_vld <= 1'b0;
    end else begin
      omega_vld <= update_in;  // first pipe stage
      if (update_in) begin
        omega <= omega_nxt;
      end
    end
  end

endmodule

`default_nettype wire
